//--- Makefile
SIM      := verilator
TOP      := tb_cpu_mem_front
FILELIST := vlog.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit code of the simulator
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/bus_memory_model.sv
`timescale 1ns/1ns
//####################
// bus slave for the testbench, 256 words with a random ready delay
// contents are filled during reset from the word index
//####################
module bus_memory_model
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  bus_req_t i_bus_req,
    output bus_rsp_t o_bus_rsp
);

    localparam int WORDS = 256;

    word_t      mem [WORDS];
    integer     seed = 32'h8522;
    // cycles already spent on the open transfer
    logic [1:0] wait_q;
    // extra cycles the open transfer has to wait, 0 to 3
    logic [1:0] delay_q;
    logic [7:0] idx;
    word_t      draw;

    // word index from address bits 9:2, higher bits alias
    assign idx = i_bus_req.addr[9:2];

    // zero delay answers in the request cycle
    always_comb begin
        o_bus_rsp.ready = i_bus_req.req && (wait_q == delay_q);
        o_bus_rsp.rdata = mem[idx];
    end

    always @(posedge clk) begin
        if (!i_rst_n) begin
            // index in the upper half, its inverse in the lower half
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= {i[15:0], ~i[15:0]};
            end
            wait_q  <= '0;
            delay_q <= '0;
        end else if (o_bus_rsp.ready) begin
            if (i_bus_req.we) begin
                mem[idx] <= i_bus_req.wdata;
            end
            // new latency for the next transfer
            draw = $random(seed);
            wait_q  <= '0;
            delay_q <= draw[1:0];
        end else if (i_bus_req.req) begin
            wait_q <= wait_q + 2'd1;
        end
    end

endmodule

//--- dv/tb_cpu_mem_front.sv
`timescale 1ns/1ns
//####################
// testbench for the cpu memory front
// stimulus drives fetch and load/store, assertions check the results
//####################
module tb_cpu_mem_front
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    // about 900 cycles of tests, rest is margin
    localparam int WATCHDOG_CYCLES = 4000;
    localparam int UNIT_FETCH      = 0;
    localparam int UNIT_LSU        = 1;
    localparam int UNIT_BUS        = 2;

    typedef enum logic [1:0] {
        STALL_OFF,
        STALL_RAND,
        STALL_HOLD
    } stall_mode_t;

    logic        clk = 1'b0;
    logic        i_rst_n;
    logic        i_redirect;
    word_t       i_redirect_pc;
    logic        i_fetch_stall;
    logic        i_lsu_valid;
    lsu_req_t    i_lsu_req;
    bus_rsp_t    i_bus_rsp;
    fetch_out_t  o_fetch;
    logic        o_fetch_valid;
    logic        o_lsu_busy;
    lsu_rsp_t    o_lsu_rsp;
    logic        o_lsu_rsp_valid;
    bus_req_t    o_bus_req;

    integer      seed = 32'h8522;
    int          errs [3] = '{0, 0, 0};
    word_t       shadow [256];
    stall_mode_t stall_mode;
    logic        stall_draw;

    // fetch scoreboard, next item expected at the consumer
    word_t       exp_pc;
    logic        exp_mis;
    int          fetch_count;
    logic        fetch_take;
    word_t       exp_instr;
    exc_code_t   exp_fexc;

    // expectations for the load/store op in flight
    word_t       exp_rdata;
    exc_code_t   exp_exc;
    logic        exp_wr_ok;
    word_t       exp_waddr;
    word_t       exp_wword;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_mem_front u_dut (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_redirect      (i_redirect),
        .i_redirect_pc   (i_redirect_pc),
        .i_fetch_stall   (i_fetch_stall),
        .i_lsu_valid     (i_lsu_valid),
        .i_lsu_req       (i_lsu_req),
        .i_bus_rsp       (i_bus_rsp),
        .o_fetch         (o_fetch),
        .o_fetch_valid   (o_fetch_valid),
        .o_lsu_busy      (o_lsu_busy),
        .o_lsu_rsp       (o_lsu_rsp),
        .o_lsu_rsp_valid (o_lsu_rsp_valid),
        .o_bus_req       (o_bus_req)
    );

    bus_memory_model u_mem (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_bus_req (o_bus_req),
        .o_bus_rsp (i_bus_rsp)
    );

    // memory contents at reset, index above and its inverse below
    function automatic word_t init_word(input logic [7:0] idx);
        return {8'd0, idx, 8'hFF, ~idx};
    endfunction

    task automatic flag_value(input int unit, input string name, input word_t got,
                              input word_t exp);
        errs[unit]++;
        $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic flag_event(input int unit, input string what);
        errs[unit]++;
        $display("error at %0t: %s", $time, what);
    endtask

    // a consumed item is valid with no stall
    assign fetch_take = o_fetch_valid && !i_fetch_stall;
    // fetch region is never written, so the reset contents hold
    assign exp_instr  = exp_mis ? '0 : init_word(exp_pc[9:2]);
    assign exp_fexc   = exp_mis ? EXC_IA_MISALIGNED : EXC_NONE;

    always @(posedge clk) begin
        if (!i_rst_n) begin
            exp_pc      <= '0;
            exp_mis     <= 1'b0;
            fetch_count <= 0;
        end else begin
            // a redirect replaces whatever was pending
            if (i_redirect) begin
                exp_pc  <= i_redirect_pc;
                exp_mis <= (i_redirect_pc[1:0] != 2'b00);
            end else if (fetch_take) begin
                exp_pc <= exp_pc + 32'd4;
            end
            if (fetch_take) begin
                fetch_count <= fetch_count + 1;
            end
        end
    end

    // stall drawn off the rising edge and applied on it
    always @(negedge clk) begin
        stall_draw <= ($random(seed) & 1) != 0;
    end

    always @(posedge clk) begin
        case (stall_mode)
            STALL_RAND: i_fetch_stall <= stall_draw;
            STALL_HOLD: i_fetch_stall <= 1'b1;
            default:    i_fetch_stall <= 1'b0;
        endcase
    end

    a_fetch_pc: assert property (@(posedge clk) disable iff (!i_rst_n)
        fetch_take |-> o_fetch.pc == exp_pc)
        else flag_value(UNIT_FETCH, "o_fetch.pc", $sampled(o_fetch.pc), $sampled(exp_pc));
    a_fetch_instr: assert property (@(posedge clk) disable iff (!i_rst_n)
        fetch_take |-> o_fetch.instr == exp_instr)
        else flag_value(UNIT_FETCH, "o_fetch.instr", $sampled(o_fetch.instr),
                        $sampled(exp_instr));
    a_fetch_exc: assert property (@(posedge clk) disable iff (!i_rst_n)
        fetch_take |-> o_fetch.exc == exp_fexc)
        else flag_value(UNIT_FETCH, "o_fetch.exc", word_t'($sampled(o_fetch.exc)),
                        word_t'($sampled(exp_fexc)));
    a_lsu_rdata: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_lsu_rsp_valid |-> o_lsu_rsp.rdata == exp_rdata)
        else flag_value(UNIT_LSU, "o_lsu_rsp.rdata", $sampled(o_lsu_rsp.rdata),
                        $sampled(exp_rdata));
    a_lsu_exc: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_lsu_rsp_valid |-> o_lsu_rsp.exc == exp_exc)
        else flag_value(UNIT_LSU, "o_lsu_rsp.exc", word_t'($sampled(o_lsu_rsp.exc)),
                        word_t'($sampled(exp_exc)));
    // misaligned fetch targets never reach the bus
    a_bus_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_bus_req.req |-> o_bus_req.addr[1:0] == 2'b00)
        else flag_value(UNIT_BUS, "o_bus_req.addr", $sampled(o_bus_req.addr),
                        {$sampled(o_bus_req.addr[31:2]), 2'b00});
    a_write_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_bus_req.req && o_bus_req.we |-> o_lsu_busy)
        else flag_event(UNIT_BUS, "bus write while the load/store unit is idle");
    a_write_store: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_bus_req.req && o_bus_req.we |-> exp_wr_ok)
        else flag_event(UNIT_BUS, "bus write without an aligned store in progress");
    a_write_addr: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_bus_req.req && o_bus_req.we && exp_wr_ok |-> o_bus_req.addr == exp_waddr)
        else flag_value(UNIT_BUS, "o_bus_req.addr", $sampled(o_bus_req.addr),
                        $sampled(exp_waddr));
    // sub-word stores write back the merged word
    a_write_data: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_bus_req.req && o_bus_req.we && exp_wr_ok |-> o_bus_req.wdata == exp_wword)
        else flag_value(UNIT_BUS, "o_bus_req.wdata", $sampled(o_bus_req.wdata),
                        $sampled(exp_wword));

    task automatic redirect_to(input word_t pc);
        @(posedge clk);
        i_redirect    <= 1'b1;
        i_redirect_pc <= pc;
        @(posedge clk);
        i_redirect    <= 1'b0;
    endtask

    task automatic wait_fetch_items(input int n);
        int base;
        @(negedge clk);
        base = fetch_count;
        while (fetch_count < base + n) begin
            @(negedge clk);
        end
    endtask

    // one load or store, expectations from the shadow, then wait for the response
    task automatic issue_lsu(input word_t addr, input word_t wdata, input access_size_t size,
                             input logic write, input logic sgn);
        logic [7:0]  idx;
        logic [4:0]  pos;
        logic [7:0]  lane8;
        logic [15:0] lane16;
        logic        bad;
        word_t       old_w;
        word_t       new_w;
        word_t       rd;
        idx   = addr[9:2];
        old_w = shadow[idx];
        new_w = old_w;
        rd    = old_w;
        bad   = 1'b0;
        if (size == SIZE_BYTE) begin
            // big-endian, offset 0 is bits 31:24
            pos   = {~addr[1:0], 3'b000};
            lane8 = old_w[pos +: 8];
            new_w[pos +: 8] = wdata[7:0];
            rd = sgn ? {{24{lane8[7]}}, lane8} : {24'd0, lane8};
        end else if (size == SIZE_HALF) begin
            bad    = addr[0];
            pos    = {~addr[1], 4'b0000};
            lane16 = old_w[pos +: 16];
            new_w[pos +: 16] = wdata[15:0];
            rd = sgn ? {{16{lane16[15]}}, lane16} : {16'd0, lane16};
        end else begin
            bad   = (addr[1:0] != 2'b00);
            new_w = wdata;
        end
        @(posedge clk);
        i_lsu_valid           <= 1'b1;
        i_lsu_req.addr        <= addr;
        i_lsu_req.wdata       <= wdata;
        i_lsu_req.size        <= size;
        i_lsu_req.write       <= write;
        i_lsu_req.load_signed <= sgn;
        exp_exc   <= bad ? EXC_DA_MISALIGNED : EXC_NONE;
        exp_rdata <= (bad || write) ? 32'd0 : rd;
        exp_wr_ok <= write && !bad;
        exp_waddr <= {addr[31:2], 2'b00};
        exp_wword <= new_w;
        if (write && !bad) begin
            shadow[idx] = new_w;
        end
        @(posedge clk);
        i_lsu_valid <= 1'b0;
        @(negedge clk);
        while (!o_lsu_rsp_valid) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        word_t r;
        word_t wd;
        int    total;
        i_rst_n       = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_fetch_stall = 1'b0;
        i_lsu_valid   = 1'b0;
        i_lsu_req     = '0;
        stall_mode    = STALL_OFF;
        exp_wr_ok     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = init_word(i[7:0]);
        end
        repeat (16) @(posedge clk);
        i_rst_n    <= 1'b1;
        stall_mode <= STALL_RAND;

        // sequential fetch under random back-pressure
        redirect_to(32'h100);
        wait_fetch_items(12);
        // misaligned target gives one exception item, then fetch idles
        redirect_to(32'h102);
        wait_fetch_items(1);
        redirect_to(32'h0C0);
        wait_fetch_items(4);
        stall_mode <= STALL_HOLD;

        // word round trip
        issue_lsu(32'h200, 32'hCAFE_BABE, SIZE_WORD, 1'b1, 1'b0);
        issue_lsu(32'h200, '0, SIZE_WORD, 1'b0, 1'b0);
        // sub-word stores, checked through word loads
        issue_lsu(32'h204, 32'h81, SIZE_BYTE, 1'b1, 1'b0);
        issue_lsu(32'h207, 32'h7F, SIZE_BYTE, 1'b1, 1'b0);
        issue_lsu(32'h20A, 32'h8001, SIZE_HALF, 1'b1, 1'b0);
        issue_lsu(32'h204, '0, SIZE_WORD, 1'b0, 1'b0);
        issue_lsu(32'h208, '0, SIZE_WORD, 1'b0, 1'b0);
        // sub-word loads, signed and unsigned
        issue_lsu(32'h204, '0, SIZE_BYTE, 1'b0, 1'b1);
        issue_lsu(32'h204, '0, SIZE_BYTE, 1'b0, 1'b0);
        issue_lsu(32'h207, '0, SIZE_BYTE, 1'b0, 1'b1);
        issue_lsu(32'h20A, '0, SIZE_HALF, 1'b0, 1'b1);
        issue_lsu(32'h20A, '0, SIZE_HALF, 1'b0, 1'b0);
        issue_lsu(32'h208, '0, SIZE_HALF, 1'b0, 1'b1);
        // misaligned accesses, the word at 0x210 stays as it was
        issue_lsu(32'h211, 32'hDEAD_BEEF, SIZE_WORD, 1'b1, 1'b0);
        issue_lsu(32'h213, 32'h1234, SIZE_HALF, 1'b1, 1'b0);
        issue_lsu(32'h216, '0, SIZE_WORD, 1'b0, 1'b0);
        issue_lsu(32'h210, '0, SIZE_WORD, 1'b0, 1'b0);

        // contention, random data ops in 0x300-0x3ff while fetch runs from 0
        stall_mode <= STALL_RAND;
        redirect_to(32'h000);
        for (int n = 0; n < 24; n++) begin
            r  = $random(seed);
            wd = $random(seed);
            issue_lsu({22'd0, 2'b11, r[7:0]}, wd, access_size_t'(r[9:8] % 2'd3), r[10], r[11]);
        end
        for (word_t a = 32'h300; a < 32'h340; a += 32'd4) begin
            issue_lsu(a, '0, SIZE_WORD, 1'b0, 1'b0);
        end
        stall_mode <= STALL_HOLD;
        repeat (4) @(posedge clk);

        total = errs[UNIT_FETCH] + errs[UNIT_LSU] + errs[UNIT_BUS];
        $display("errors: fetch %0d, load/store %0d, bus %0d",
                 errs[UNIT_FETCH], errs[UNIT_LSU], errs[UNIT_BUS]);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ns
//####################
// fixed-priority arbiter, data over fetch
// the owner keeps the bus until its ready cycle
//####################
module bus_arbiter
    import cpu_bus_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  bus_req_t i_fetch_req,
    input  bus_req_t i_data_req,
    input  bus_rsp_t i_bus_rsp,
    output bus_rsp_t o_fetch_rsp,
    output bus_rsp_t o_data_rsp,
    output bus_req_t o_bus_req
);

    logic owner_q;
    logic locked_q;
    logic owner;

    // free bus picks combinationally, so a grant costs no cycle
    always_comb begin
        if (locked_q) begin
            owner = owner_q;
        end else if (i_data_req.req) begin
            owner = MASTER_DATA;
        end else begin
            owner = MASTER_FETCH;
        end
    end

    assign o_bus_req = (owner == MASTER_DATA) ? i_data_req : i_fetch_req;

    // rdata fans out, ready only to the owner
    always_comb begin
        o_fetch_rsp       = i_bus_rsp;
        o_data_rsp        = i_bus_rsp;
        o_fetch_rsp.ready = i_bus_rsp.ready && (owner == MASTER_FETCH);
        o_data_rsp.ready  = i_bus_rsp.ready && (owner == MASTER_DATA);
    end

    // lock across a transfer that did not finish this cycle
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            owner_q  <= MASTER_FETCH;
            locked_q <= 1'b0;
        end else if (o_bus_req.req && !i_bus_rsp.ready) begin
            owner_q  <= owner;
            locked_q <= 1'b1;
        end else begin
            locked_q <= 1'b0;
        end
    end

    // an open transfer keeps its owner, and the bus sees the same request
    // even if the other master starts asking meanwhile
    a_owner_locked: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_bus_req.req && !i_bus_rsp.ready |=> owner == $past(owner) && $stable(o_bus_req)
    );

endmodule

//--- rtl/cpu_bus_pkg.sv
//####################
// shared external bus, request/response words and master ids
//####################
package cpu_bus_pkg;

    import cpu_isa_pkg::word_t;

    // master side of one transfer
    // held stable from req rise until the ready cycle
    typedef struct packed {
        logic  req;
        logic  we;
        word_t addr;
        word_t wdata;
    } bus_req_t;

    // slave side, rdata valid only with ready
    typedef struct packed {
        logic  ready;
        word_t rdata;
    } bus_rsp_t;

    // owner encoding inside the arbiter
    localparam logic MASTER_FETCH = 1'b0;
    localparam logic MASTER_DATA  = 1'b1;

endpackage

//--- rtl/cpu_isa_pkg.sv
//####################
// isa-side types for instruction fetch and the load/store path
// modules pull these in with a wildcard import in their header
//####################
package cpu_isa_pkg;

    // one data or address word
    typedef logic [31:0] word_t;

    // exception cause, same encoding as the full pipeline
    typedef logic [3:0] exc_code_t;

    localparam exc_code_t EXC_NONE          = 4'd0;
    localparam exc_code_t EXC_IA_MISALIGNED = 4'd1;
    localparam exc_code_t EXC_DA_MISALIGNED = 4'd8;

    // sequential fetch moves one word at a time
    localparam word_t INSTR_STEP = 32'd4;

    // width of one load/store access
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    // request from the pipeline into the load/store unit
    typedef struct packed {
        word_t        addr;
        word_t        wdata;
        access_size_t size;
        logic         write;
        logic         load_signed;
    } lsu_req_t;

    // load result, or zero for a store
    typedef struct packed {
        word_t     rdata;
        exc_code_t exc;
    } lsu_rsp_t;

    // one fetched instruction with its address
    typedef struct packed {
        word_t     pc;
        word_t     instr;
        exc_code_t exc;
    } fetch_out_t;

    // big-endian lanes, index 0 is the most significant one
    // byte offset 0 lands on lane_b[0], halfword offset 0 on lane_h[0]
    typedef union packed {
        logic [0:3][7:0]  lane_b;
        logic [0:1][15:0] lane_h;
    } lane_word_u;

endpackage

//--- rtl/cpu_mem_front.sv
`timescale 1ns/1ns
//####################
// memory side of the cpu, fetch and load/store on one bus
//####################
module cpu_mem_front
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_redirect,
    input  word_t      i_redirect_pc,
    input  logic       i_fetch_stall,
    input  logic       i_lsu_valid,
    input  lsu_req_t   i_lsu_req,
    input  bus_rsp_t   i_bus_rsp,
    output fetch_out_t o_fetch,
    output logic       o_fetch_valid,
    output logic       o_lsu_busy,
    output lsu_rsp_t   o_lsu_rsp,
    output logic       o_lsu_rsp_valid,
    output bus_req_t   o_bus_req
);

    // master-side links to the arbiter
    bus_req_t fetch_req;
    bus_rsp_t fetch_rsp;
    bus_req_t data_req;
    bus_rsp_t data_rsp;

    fetch_unit u_fetch (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_fetch_stall (i_fetch_stall),
        .i_bus_rsp     (fetch_rsp),
        .o_bus_req     (fetch_req),
        .o_fetch       (o_fetch),
        .o_fetch_valid (o_fetch_valid)
    );

    load_store_unit u_lsu (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_lsu_valid     (i_lsu_valid),
        .i_lsu_req       (i_lsu_req),
        .i_bus_rsp       (data_rsp),
        .o_bus_req       (data_req),
        .o_lsu_busy      (o_lsu_busy),
        .o_lsu_rsp       (o_lsu_rsp),
        .o_lsu_rsp_valid (o_lsu_rsp_valid)
    );

    bus_arbiter u_arb (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_fetch_req (fetch_req),
        .i_data_req  (data_req),
        .i_bus_rsp   (i_bus_rsp),
        .o_fetch_rsp (fetch_rsp),
        .o_data_rsp  (data_rsp),
        .o_bus_req   (o_bus_req)
    );

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ns
//####################
// sequential instruction fetch, one bus word in flight
// a redirect starts it, the consumer drains items by valid/stall
//####################
module fetch_unit
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_redirect,
    input  word_t      i_redirect_pc,
    input  logic       i_fetch_stall,
    input  bus_rsp_t   i_bus_rsp,
    output bus_req_t   o_bus_req,
    output fetch_out_t o_fetch,
    output logic       o_fetch_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_HOLD
    } state_t;

    state_t    state_q;
    state_t    state_d;
    logic      pend_q;
    logic      pend_d;
    word_t     pend_pc_q;
    // pc_q is the bus address while busy and the item pc while holding
    word_t     pc_q;
    word_t     instr_q;
    exc_code_t exc_q;

    logic      xfer_done;
    logic      pend_set;
    logic      take_en;
    word_t     take_pc;
    logic      take_ok;
    logic      consume;

    assign xfer_done = (state_q == ST_BUSY) && i_bus_rsp.ready;
    // redirect mid-transfer, park the target and drop the data later
    assign pend_set  = (state_q == ST_BUSY) && !i_bus_rsp.ready && i_redirect;
    // new target now, or the parked one once the old transfer ends
    assign take_en   = (i_redirect && !pend_set) || (xfer_done && pend_q);
    assign take_pc   = i_redirect ? i_redirect_pc : pend_pc_q;
    assign take_ok   = (take_pc[1:0] == 2'b00);
    assign consume   = (state_q == ST_HOLD) && !i_fetch_stall;

    always_comb begin
        state_d = state_q;
        pend_d  = pend_q;
        if (pend_set) begin
            pend_d = 1'b1;
        end else if (take_en) begin
            pend_d = 1'b0;
            // misaligned target goes straight to an exception item
            state_d = take_ok ? ST_BUSY : ST_HOLD;
        end else if (xfer_done) begin
            state_d = ST_HOLD;
        end else if (consume) begin
            // after an exception item fetch waits for a redirect
            state_d = (exc_q == EXC_NONE) ? ST_BUSY : ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            pend_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_d;
        end
    end

    always_ff @(posedge clk) begin
        if (pend_set) begin
            pend_pc_q <= i_redirect_pc;
        end else if (take_en) begin
            pc_q    <= take_pc;
            instr_q <= '0;
            exc_q   <= take_ok ? EXC_NONE : EXC_IA_MISALIGNED;
        end else if (xfer_done) begin
            instr_q <= i_bus_rsp.rdata;
            exc_q   <= EXC_NONE;
        end else if (consume && exc_q == EXC_NONE) begin
            pc_q <= pc_q + INSTR_STEP;
        end
    end

    // read-only master
    always_comb begin
        o_bus_req.req   = (state_q == ST_BUSY);
        o_bus_req.we    = 1'b0;
        o_bus_req.addr  = pc_q;
        o_bus_req.wdata = '0;
    end

    assign o_fetch_valid = (state_q == ST_HOLD);

    always_comb begin
        o_fetch.pc    = pc_q;
        o_fetch.instr = instr_q;
        o_fetch.exc   = exc_q;
    end

    // bus rule, nothing moves until the ready cycle
    a_req_stable: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_bus_req.req && !i_bus_rsp.ready |=> o_bus_req.req && $stable(o_bus_req)
    );

endmodule

//--- rtl/load_store_unit.sv
`timescale 1ns/1ns
//####################
// load/store sequencer on the shared bus
// sub-word stores run as read, lane merge, write
//####################
module load_store_unit
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_lsu_valid,
    input  lsu_req_t i_lsu_req,
    input  bus_rsp_t i_bus_rsp,
    output bus_req_t o_bus_req,
    output logic     o_lsu_busy,
    output lsu_rsp_t o_lsu_rsp,
    output logic     o_lsu_rsp_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_RSP
    } state_t;

    state_t     state_q;
    state_t     state_d;
    lsu_req_t   req_q;
    // store word going out, or raw word read back
    word_t      data_q;
    exc_code_t  exc_q;

    logic       accept;
    logic       misaligned;
    logic       in_sub_word;
    logic [1:0] offset;
    lane_word_u merge_lane;
    lane_word_u load_lane;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t      load_data;

    assign accept      = i_lsu_valid && (state_q == ST_IDLE);
    assign in_sub_word = (i_lsu_req.size != SIZE_WORD);
    assign offset      = req_q.addr[1:0];

    // word on a 4-byte boundary, half on 2, byte anywhere
    always_comb begin
        case (i_lsu_req.size)
            SIZE_WORD: misaligned = (i_lsu_req.addr[1:0] != 2'b00);
            SIZE_HALF: misaligned = i_lsu_req.addr[0];
            default:   misaligned = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept && misaligned) begin
                    // no bus traffic, answer next cycle
                    state_d = ST_RSP;
                end else if (accept && i_lsu_req.write && !in_sub_word) begin
                    state_d = ST_WRITE;
                end else if (accept) begin
                    state_d = ST_READ;
                end
            end
            ST_READ: begin
                // only a sub-word store needs the write pass
                if (i_bus_rsp.ready) begin
                    state_d = req_q.write ? ST_WRITE : ST_RSP;
                end
            end
            ST_WRITE: begin
                if (i_bus_rsp.ready) begin
                    state_d = ST_RSP;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q  <= i_lsu_req;
            data_q <= i_lsu_req.wdata;
            exc_q  <= misaligned ? EXC_DA_MISALIGNED : EXC_NONE;
        end else if (state_q == ST_READ && i_bus_rsp.ready) begin
            data_q <= req_q.write ? word_t'(merge_lane) : i_bus_rsp.rdata;
        end
    end

    // replace one lane of the word just read
    always_comb begin
        merge_lane = i_bus_rsp.rdata;
        case (req_q.size)
            SIZE_BYTE: merge_lane.lane_b[offset] = req_q.wdata[7:0];
            SIZE_HALF: merge_lane.lane_h[offset[1]] = req_q.wdata[15:0];
            default:   merge_lane = req_q.wdata;
        endcase
    end

    // pick the lane back out, then sign or zero extend
    always_comb begin
        load_lane = data_q;
        load_byte = load_lane.lane_b[offset];
        load_half = load_lane.lane_h[offset[1]];
        case (req_q.size)
            SIZE_BYTE: load_data = {{24{req_q.load_signed & load_byte[7]}}, load_byte};
            SIZE_HALF: load_data = {{16{req_q.load_signed & load_half[15]}}, load_half};
            default:   load_data = data_q;
        endcase
    end

    // bus always sees the word address
    always_comb begin
        o_bus_req.req   = (state_q == ST_READ) || (state_q == ST_WRITE);
        o_bus_req.we    = (state_q == ST_WRITE);
        o_bus_req.addr  = {req_q.addr[31:2], 2'b00};
        o_bus_req.wdata = data_q;
    end

    assign o_lsu_busy      = (state_q != ST_IDLE);
    assign o_lsu_rsp_valid = (state_q == ST_RSP);

    // stores and faults return zero data
    always_comb begin
        o_lsu_rsp.rdata = (req_q.write || exc_q != EXC_NONE) ? '0 : load_data;
        o_lsu_rsp.exc   = exc_q;
    end

    // a strobe while busy would be dropped
    a_no_accept_busy: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_lsu_valid |-> !o_lsu_busy
    );

    // writes come only from an accepted, aligned store
    a_write_is_store: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_bus_req.req && o_bus_req.we |-> req_q.write && exc_q == EXC_NONE
    );

endmodule

//--- vlog.f
rtl/cpu_isa_pkg.sv
rtl/cpu_bus_pkg.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/bus_arbiter.sv
rtl/cpu_mem_front.sv
dv/bus_memory_model.sv
dv/tb_cpu_mem_front.sv
